// ==== design/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////////////////////////
`define CACHE_WAYS 4
`define CACHE_SETS 256
`define INDEX_BITS 8
`define TAG_BITS 22

//////////////////////////////////////////////////////////////////////
// Main memory model
//////////////////////////////////////////////////////////////////////
`define MEM_ADDR_BITS 12
`define MEM_READ_LATENCY 3

// Word n holds this base plus n after reset
`define MEM_INIT_BASE 32'hA5A5_0000

`endif

// ==== design/cache_pkg.sv ====
`include "cache_defines.svh"

package cache_pkg;

    // Byte address split for the arrays
    typedef struct packed {
        logic [`TAG_BITS-1:0]   tag;
        logic [`INDEX_BITS-1:0] index;
        logic [1:0]             offset;
    } cache_addr_t;

    // Same address seen flat or by field
    typedef union packed {
        logic [31:0] flat;
        cache_addr_t fields;
    } cache_addr_u;

    // Requester side
    typedef struct packed {
        logic        write;
        cache_addr_u addr;
        logic [31:0] write_data;
    } cpu_req_t;

    typedef struct packed {
        logic        read_ready;
        logic [31:0] read_data;
    } cpu_rsp_t;

    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_sel_t;

endpackage

// ==== design/mem_pkg.sv ====
package mem_pkg;

    // Read request level with a word aligned byte address
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } mem_rd_req_t;

    // One cycle read response
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } mem_rd_rsp_t;

    // Write strobe stored at the edge
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } mem_wr_req_t;

endpackage

// ==== design/cache_way.sv ====
`include "cache_defines.svh"

module cache_way (
    input  logic                   CLK,
    input  logic                   Reset,
    input  cache_pkg::cache_addr_u addr,
    input  logic                   write_en,
    input  logic [31:0]            write_data,
    input  logic                   dirty_in,
    output logic                   hit,
    output logic                   valid,
    output logic                   dirty,
    output logic [31:0]            read_data,
    output logic [`TAG_BITS-1:0]   line_tag
);

    logic [`CACHE_SETS-1:0] valid_bits;
    logic [`CACHE_SETS-1:0] dirty_bits;
    logic [`TAG_BITS-1:0]   tag_mem  [`CACHE_SETS];
    logic [31:0]            data_mem [`CACHE_SETS];

    logic [`INDEX_BITS-1:0] index;
    logic [`TAG_BITS-1:0]   req_tag;

    assign index   = addr.fields.index;
    assign req_tag = addr.fields.tag;

    //////////////////////////////////////////////////////////////////////
    // Combinational lookup
    //////////////////////////////////////////////////////////////////////

    assign valid     = valid_bits[index];
    assign dirty     = dirty_bits[index];
    assign line_tag  = tag_mem[index];
    assign read_data = data_mem[index];

    // Entry must be valid for the tag compare to count
    assign hit = valid && (line_tag == req_tag);

    //////////////////////////////////////////////////////////////////////
    // Line update
    //////////////////////////////////////////////////////////////////////

    // Status bits
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (write_en) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= dirty_in;
        end
    end

    // Tag and data storage
    always_ff @(posedge CLK) begin
        if (write_en) begin
            tag_mem[index]  <= req_tag;
            data_mem[index] <= write_data;
        end
    end

endmodule

// ==== design/cache_ctrl.sv ====
`include "cache_defines.svh"

module cache_ctrl (
    input  logic                 CLK,
    input  logic                 Reset,
    input  logic                 req_valid,
    input  cache_pkg::cpu_req_t  req,
    output logic                 ready,
    output cache_pkg::cpu_rsp_t  rsp,
    output mem_pkg::mem_rd_req_t mem_rd_req,
    input  mem_pkg::mem_rd_rsp_t mem_rd_rsp,
    output mem_pkg::mem_wr_req_t mem_wr_req
);

    import cache_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_FILL
    } state_t;

    state_t state;
    state_t state_next;

    logic [`CACHE_WAYS-1:0] way_hit;
    logic [`CACHE_WAYS-1:0] way_valid;
    logic [`CACHE_WAYS-1:0] way_dirty;
    logic [`CACHE_WAYS-1:0] way_we;
    logic [31:0]            way_rdata [`CACHE_WAYS];
    logic [`TAG_BITS-1:0]   way_tag   [`CACHE_WAYS];

    logic        any_hit;
    way_sel_t    hit_way;
    way_sel_t    victim;
    logic        victim_found;
    logic        idle;
    logic        do_write;
    logic        rd_miss;
    logic        do_fill;
    logic        evict;
    logic        line_dirty;
    logic [31:0] line_data;
    cache_addr_u wb_addr;

    //////////////////////////////////////////////////////////////////////
    // Ways
    //////////////////////////////////////////////////////////////////////

    cache_way way_0 (
        .CLK        (CLK),
        .Reset      (Reset),
        .addr       (req.addr),
        .write_en   (way_we[0]),
        .write_data (line_data),
        .dirty_in   (line_dirty),
        .hit        (way_hit[0]),
        .valid      (way_valid[0]),
        .dirty      (way_dirty[0]),
        .read_data  (way_rdata[0]),
        .line_tag   (way_tag[0])
    );

    cache_way way_1 (
        .CLK        (CLK),
        .Reset      (Reset),
        .addr       (req.addr),
        .write_en   (way_we[1]),
        .write_data (line_data),
        .dirty_in   (line_dirty),
        .hit        (way_hit[1]),
        .valid      (way_valid[1]),
        .dirty      (way_dirty[1]),
        .read_data  (way_rdata[1]),
        .line_tag   (way_tag[1])
    );

    cache_way way_2 (
        .CLK        (CLK),
        .Reset      (Reset),
        .addr       (req.addr),
        .write_en   (way_we[2]),
        .write_data (line_data),
        .dirty_in   (line_dirty),
        .hit        (way_hit[2]),
        .valid      (way_valid[2]),
        .dirty      (way_dirty[2]),
        .read_data  (way_rdata[2]),
        .line_tag   (way_tag[2])
    );

    cache_way way_3 (
        .CLK        (CLK),
        .Reset      (Reset),
        .addr       (req.addr),
        .write_en   (way_we[3]),
        .write_data (line_data),
        .dirty_in   (line_dirty),
        .hit        (way_hit[3]),
        .valid      (way_valid[3]),
        .dirty      (way_dirty[3]),
        .read_data  (way_rdata[3]),
        .line_tag   (way_tag[3])
    );

    //////////////////////////////////////////////////////////////////////
    // Hit mux and victim choice
    //////////////////////////////////////////////////////////////////////

    assign any_hit = |way_hit;

    // Lowest hitting way wins
    always_comb begin
        hit_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = way_sel_t'(w);
            end
        end
    end

    // First invalid, then first clean, else way 0
    always_comb begin
        victim       = '0;
        victim_found = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!victim_found && !way_valid[w]) begin
                victim       = way_sel_t'(w);
                victim_found = 1'b1;
            end
        end
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!victim_found && !way_dirty[w]) begin
                victim       = way_sel_t'(w);
                victim_found = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    assign idle     = (state == ST_IDLE);
    assign do_write = idle && req_valid && req.write;
    assign rd_miss  = idle && req_valid && !req.write && !any_hit;
    assign do_fill  = (state == ST_FILL) && mem_rd_rsp.valid;

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: if (rd_miss) state_next = ST_FILL;
            ST_FILL: if (mem_rd_rsp.valid) state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    // Hit write to its own way, miss write or fill to the victim
    always_comb begin
        way_we = '0;
        if (do_write && any_hit) begin
            way_we[hit_way] = 1'b1;
        end else if (do_write || do_fill) begin
            way_we[victim] = 1'b1;
        end
    end

    assign line_data  = do_fill ? mem_rd_rsp.data : req.write_data;
    assign line_dirty = !do_fill;

    // Old line goes out at the edge it is replaced
    assign evict = ((do_write && !any_hit) || do_fill)
                   && way_valid[victim] && way_dirty[victim];

    always_comb begin
        wb_addr.fields.tag    = way_tag[victim];
        wb_addr.fields.index  = req.addr.fields.index;
        wb_addr.fields.offset = 2'b00;
    end

    assign mem_wr_req.valid = evict;
    assign mem_wr_req.addr  = wb_addr.flat;
    assign mem_wr_req.data  = way_rdata[victim];

    // Held high until the fill arrives
    assign mem_rd_req.valid = rd_miss || (state == ST_FILL);
    assign mem_rd_req.addr  = {req.addr.flat[31:2], 2'b00};

    assign ready          = idle;
    assign rsp.read_ready = idle && req_valid && !req.write && any_hit;
    assign rsp.read_data  = way_rdata[hit_way];

endmodule

// ==== design/main_mem.sv ====
`include "cache_defines.svh"

module main_mem (
    input  logic                 CLK,
    input  logic                 Reset,
    input  mem_pkg::mem_rd_req_t rd_req,
    output mem_pkg::mem_rd_rsp_t rd_rsp,
    input  mem_pkg::mem_wr_req_t wr_req
);

    localparam int MEM_WORDS = 2 ** `MEM_ADDR_BITS;
    localparam int CNT_BITS  = $clog2(`MEM_READ_LATENCY + 1);

    logic [31:0]               mem [MEM_WORDS];
    logic                      busy;
    logic [CNT_BITS-1:0]       count;
    logic [`MEM_ADDR_BITS-1:0] rd_addr;
    logic [`MEM_ADDR_BITS-1:0] wr_addr;

    assign wr_addr = wr_req.addr[`MEM_ADDR_BITS+1:2];

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // Known pattern after reset
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= `MEM_INIT_BASE + 32'(i);
            end
        end else if (wr_req.valid) begin
            mem[wr_addr] <= wr_req.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read latency
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (!busy) begin
            if (rd_req.valid) begin
                busy  <= 1'b1;
                count <= CNT_BITS'(`MEM_READ_LATENCY - 1);
            end
        end else if (count == '0) begin
            busy <= 1'b0;
        end else begin
            count <= count - 1'b1;
        end
    end

    // Address sampled only while idle
    always_ff @(posedge CLK) begin
        if (!busy && rd_req.valid) begin
            rd_addr <= rd_req.addr[`MEM_ADDR_BITS+1:2];
        end
    end

    assign rd_rsp.valid = busy && (count == '0);
    assign rd_rsp.data  = mem[rd_addr];

endmodule

// ==== design/cache_subsys_top.sv ====
module cache_subsys_top (
    input  logic                CLK,
    input  logic                Reset,
    input  logic                req_valid,
    input  cache_pkg::cpu_req_t req,
    output logic                ready,
    output cache_pkg::cpu_rsp_t rsp
);

    import mem_pkg::*;

    // Buses between cache and memory
    mem_rd_req_t mem_rd_req;
    mem_rd_rsp_t mem_rd_rsp;
    mem_wr_req_t mem_wr_req;

    cache_ctrl u_cache (
        .CLK        (CLK),
        .Reset      (Reset),
        .req_valid  (req_valid),
        .req        (req),
        .ready      (ready),
        .rsp        (rsp),
        .mem_rd_req (mem_rd_req),
        .mem_rd_rsp (mem_rd_rsp),
        .mem_wr_req (mem_wr_req)
    );

    main_mem u_mem (
        .CLK    (CLK),
        .Reset  (Reset),
        .rd_req (mem_rd_req),
        .rd_rsp (mem_rd_rsp),
        .wr_req (mem_wr_req)
    );

endmodule

// ==== tests/tb_cache_subsys.sv ====
`include "cache_defines.svh"

module tb_cache_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_pkg::*;

    // One line of the vector file
    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic        miss;
    } vector_t;

    logic     CLK;
    logic     Reset;
    logic     req_valid;
    cpu_req_t req;
    logic     ready;
    cpu_rsp_t rsp;

    vector_t  vectors[$];
    logic     loaded;

    cache_subsys_top UUT (
        .CLK       (CLK),
        .Reset     (Reset),
        .req_valid (req_valid),
        .req       (req),
        .ready     (ready),
        .rsp       (rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] value,
                               input logic [31:0] expected);
        if (value !== expected) begin
            $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, value, expected);
            $display("Simulation failed");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        vector_t v;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] ed;
        int          em;
        fd = $fopen("tests/cache_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tests/cache_vectors.txt");
            $display("Simulation failed");
            $fatal(1, "No vectors");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip comments and blank lines
            if (n > 1 && line.substr(0, 1) != "//") begin
                n = $sscanf(line, "%c %h %h %h %d", op, a, wd, ed, em);
                if (n != 5 || (op != "R" && op != "W")) begin
                    $display("Malformed vector line: %s", line);
                    $display("Simulation failed");
                    $fatal(1, "Bad vector file");
                end
                v.is_write = (op == "W");
                v.addr     = a;
                v.wdata    = wd;
                v.expected = ed;
                v.miss     = (em != 0);
                vectors.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // Holds a read until read_ready and counts the cycles from the request
    task automatic read_and_check(input int idx, input vector_t v);
        int cycles;
        int want;
        want   = v.miss ? `MEM_READ_LATENCY + 1 : 0;
        cycles = 0;
        @(negedge CLK);
        while (!rsp.read_ready && cycles <= want) begin
            check_value($sformatf("vector %0d ready", idx), ready, (cycles == 0));
            @(negedge CLK);
            cycles++;
        end
        check_value($sformatf("vector %0d read_ready cycle", idx), cycles, want);
        check_value($sformatf("vector %0d ready", idx), ready, 1);
        check_value($sformatf("vector %0d read_data", idx), rsp.read_data, v.expected);
        @(posedge CLK);
        #1;
    endtask

    task automatic write_and_check(input int idx);
        @(negedge CLK);
        check_value($sformatf("vector %0d ready", idx), ready, 1);
        check_value($sformatf("vector %0d read_ready", idx), rsp.read_ready, 0);
        @(posedge CLK);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        int limit;
        wait (loaded === 1'b1);
        limit = vectors.size() * (`MEM_READ_LATENCY + 4) + 100;
        repeat (limit) @(posedge CLK);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        Reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        loaded    = 1'b0;

        load_vectors();
        loaded = 1'b1;

        repeat (5) @(posedge CLK);
        #1;
        Reset = 1'b0;

        // Idle state before any request
        @(negedge CLK);
        check_value("ready after reset", ready, 1);
        check_value("read_ready after reset", rsp.read_ready, 0);
        @(posedge CLK);
        #1;

        foreach (vectors[i]) begin
            req_valid       = 1'b1;
            req.write       = vectors[i].is_write;
            req.addr.flat   = vectors[i].addr;
            req.write_data  = vectors[i].wdata;
            if (vectors[i].is_write) begin
                write_and_check(i);
            end else begin
                read_and_check(i, vectors[i]);
            end
        end

        req_valid = 1'b0;
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+design
design/cache_pkg.sv
design/mem_pkg.sv
design/cache_way.sv
design/cache_ctrl.sv
design/main_mem.sv
design/cache_subsys_top.sv
tests/tb_cache_subsys.sv

// ==== Bender.yml ====
package:
  name: cache_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/mem_pkg.sv
      - design/cache_way.sv
      - design/cache_ctrl.sv
      - design/main_mem.sv
      - design/cache_subsys_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_cache_subsys.sv

// ==== tests/cache_vectors.txt ====
// op addr wdata expected miss
// op is R or W; for writes expected and miss are unused
R 00000010 00000000 A5A50004 1
R 00000010 00000000 A5A50004 0
W 00000020 11112222 00000000 0
R 00000020 00000000 11112222 0
W 00000010 33334444 00000000 0
R 00000010 00000000 33334444 0
W 00000040 AAAA0000 00000000 0
W 00000440 AAAA0001 00000000 0
W 00000840 AAAA0002 00000000 0
W 00000C40 AAAA0003 00000000 0
W 00001040 AAAA0004 00000000 0
R 00000440 00000000 AAAA0001 0
R 00001040 00000000 AAAA0004 0
R 00000040 00000000 AAAA0000 1
R 00001040 00000000 AAAA0004 1
R 00000040 00000000 AAAA0000 1
R 00000C40 00000000 AAAA0003 0
R 00000010 00000000 33334444 0
R 00000013 00000000 33334444 0
R 00000020 00000000 11112222 0
R 00000044 00000000 A5A50011 1
R 00000444 00000000 A5A50111 1
R 00000044 00000000 A5A50011 0
R 00003FFC 00000000 A5A50FFF 1
W 00000444 BBBB0001 00000000 0
R 00000444 00000000 BBBB0001 0
